/* rtl/decode_pkg.sv */
// ----------------------------------------------------------------------
// decode_pkg
// Widths, encodings and the micro-op record shared by the RV32I
// instruction decode stage
// ----------------------------------------------------------------------
package decode_pkg;

        localparam int XLEN      = 32;
        localparam int ARF_IDX_W = 5;

        // major opcodes kept by this decoder
        typedef enum logic [6:0] {
                OP_LUI    = 7'b0110111,
                OP_AUIPC  = 7'b0010111,
                OP_BRANCH = 7'b1100011,
                OP_LOAD   = 7'b0000011,
                OP_STORE  = 7'b0100011,
                OP_IMM    = 7'b0010011,
                OP_REG    = 7'b0110011
        } opcode_e;

        // issue queue select
        typedef enum logic [1:0] {
                IQ_NONE = 2'd0,
                IQ_INT  = 2'd1,
                IQ_MEM  = 2'd2
        } iq_code_e;

        // functional unit select
        typedef enum logic [1:0] {
                FU_NONE = 2'd0,
                FU_ALU  = 2'd1,
                FU_BR   = 2'd2,
                FU_MEM  = 2'd3
        } fu_code_e;

        // one opcode space for alu, branch and memory units
        typedef enum logic [4:0] {
                EXEC_NONE = 5'd0,
                ALU_ADD,
                ALU_SUB,
                ALU_SLL,
                ALU_SLT,
                ALU_SLTU,
                ALU_XOR,
                ALU_SRL,
                ALU_SRA,
                ALU_OR,
                ALU_AND,
                BR_EQ,
                BR_NE,
                BR_LT,
                BR_GE,
                BR_LTU,
                BR_GEU,
                MEM_LD,
                MEM_LDU,
                MEM_ST
        } exec_op_e;

        // where an operand comes from at issue
        typedef enum logic [1:0] {
                RS_FROM_RF   = 2'd0,
                RS_FROM_ZERO = 2'd1,
                RS_FROM_PC   = 2'd2,
                RS_FROM_IMM  = 2'd3
        } rs_source_e;

        // encoded as funct3[1:0] of loads and stores
        typedef enum logic [1:0] {
                MEM_BYTE = 2'd0,
                MEM_HALF = 2'd1,
                MEM_WORD = 2'd2
        } mem_size_e;

        typedef enum logic [2:0] {
                IMM_NONE  = 3'd0,
                IMM_I     = 3'd1,
                IMM_S     = 3'd2,
                IMM_U     = 3'd3,
                IMM_SHAMT = 3'd4
        } imm_fmt_e;

        typedef struct packed {
                logic                 valid;
                logic [XLEN-1:0]      pc;
                iq_code_e             iq_code;
                fu_code_e             fu_code;
                exec_op_e             exec_op;
                logic [XLEN-1:0]      imm;
                rs_source_e           rs1_source;
                logic [ARF_IDX_W-1:0] rs1_idx;
                rs_source_e           rs2_source;
                logic [ARF_IDX_W-1:0] rs2_idx;
                logic [ARF_IDX_W-1:0] rd_idx;
                logic                 rd_valid;
                mem_size_e            mem_size;
        } micro_op_t;

endpackage

/* rtl/imm_gen.sv */
// ----------------------------------------------------------------------
// imm_gen
// Extracts and extends the immediate of an RV32I instruction
// ----------------------------------------------------------------------
module imm_gen (
        input  logic [decode_pkg::XLEN-1:0] inst,
        input  decode_pkg::imm_fmt_e        fmt,
        output logic [decode_pkg::XLEN-1:0] imm
);

        import decode_pkg::*;

        always_comb begin
                case (fmt)
                        IMM_I: begin
                                imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
                        end
                        IMM_S: begin
                                imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
                        end
                        IMM_U: begin
                                imm = {inst[31:12], 12'b0};
                        end
                        // shift amount is never signed
                        IMM_SHAMT: begin
                                imm = {{(XLEN-5){1'b0}}, inst[24:20]};
                        end
                        default: begin
                                imm = '0;
                        end
                endcase
        end

endmodule

/* rtl/uop_decode.sv */
// ----------------------------------------------------------------------
// uop_decode
// Decodes one fetched RV32I instruction slot into a micro-op
// ----------------------------------------------------------------------
module uop_decode (
        input  logic [decode_pkg::XLEN-1:0] pc,
        input  logic [decode_pkg::XLEN-1:0] inst,
        input  logic                        valid,
        output decode_pkg::micro_op_t       uop
);

        import decode_pkg::*;

        opcode_e         opcode;
        logic [2:0]      funct3;
        imm_fmt_e        fmt;
        logic [XLEN-1:0] imm;
        micro_op_t       dec;
        logic            hit;

        // shared by the immediate and register alu forms
        function automatic exec_op_e alu_op(input logic [2:0] f3, input logic alt,
                                            input logic is_reg);
                case (f3)
                        3'b000:  alu_op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
                        3'b001:  alu_op = ALU_SLL;
                        3'b010:  alu_op = ALU_SLT;
                        3'b011:  alu_op = ALU_SLTU;
                        3'b100:  alu_op = ALU_XOR;
                        3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
                        3'b110:  alu_op = ALU_OR;
                        default: alu_op = ALU_AND;
                endcase
        endfunction

        assign opcode = opcode_e'(inst[6:0]);
        assign funct3 = inst[14:12];

        imm_gen u_imm_gen (
                .inst (inst),
                .fmt  (fmt),
                .imm  (imm)
        );

        always_comb begin
                dec = '0;
                fmt = IMM_NONE;
                hit = 1'b1;
                case (opcode)
                        OP_LUI, OP_AUIPC: begin
                                dec.iq_code    = IQ_INT;
                                dec.fu_code    = FU_ALU;
                                dec.exec_op    = ALU_ADD;
                                dec.rs1_source = (opcode == OP_LUI) ? RS_FROM_ZERO : RS_FROM_PC;
                                dec.rs2_source = RS_FROM_IMM;
                                dec.rd_idx     = inst[11:7];
                                dec.rd_valid   = 1'b1;
                                fmt            = IMM_U;
                        end
                        OP_BRANCH: begin
                                dec.iq_code    = IQ_INT;
                                dec.fu_code    = FU_BR;
                                dec.rs1_source = RS_FROM_RF;
                                dec.rs1_idx    = inst[19:15];
                                dec.rs2_source = RS_FROM_RF;
                                dec.rs2_idx    = inst[24:20];
                                case (funct3)
                                        3'b000:  dec.exec_op = BR_EQ;
                                        3'b001:  dec.exec_op = BR_NE;
                                        3'b100:  dec.exec_op = BR_LT;
                                        3'b101:  dec.exec_op = BR_GE;
                                        3'b110:  dec.exec_op = BR_LTU;
                                        3'b111:  dec.exec_op = BR_GEU;
                                        default: hit = 1'b0;
                                endcase
                        end
                        OP_LOAD: begin
                                dec.iq_code    = IQ_MEM;
                                dec.fu_code    = FU_MEM;
                                dec.exec_op    = funct3[2] ? MEM_LDU : MEM_LD;
                                dec.mem_size   = mem_size_e'(funct3[1:0]);
                                dec.rs1_source = RS_FROM_RF;
                                dec.rs1_idx    = inst[19:15];
                                dec.rs2_source = RS_FROM_IMM;
                                dec.rd_idx     = inst[11:7];
                                dec.rd_valid   = 1'b1;
                                fmt            = IMM_I;
                                // lb lh lw lbu lhu only
                                hit            = funct3 inside {3'b000, 3'b001, 3'b010,
                                                                3'b100, 3'b101};
                        end
                        OP_STORE: begin
                                dec.iq_code    = IQ_MEM;
                                dec.fu_code    = FU_MEM;
                                dec.exec_op    = MEM_ST;
                                dec.mem_size   = mem_size_e'(funct3[1:0]);
                                dec.rs1_source = RS_FROM_RF;
                                dec.rs1_idx    = inst[19:15];
                                dec.rs2_source = RS_FROM_RF;
                                dec.rs2_idx    = inst[24:20];
                                fmt            = IMM_S;
                                hit            = funct3 inside {3'b000, 3'b001, 3'b010};
                        end
                        OP_IMM: begin
                                dec.iq_code    = IQ_INT;
                                dec.fu_code    = FU_ALU;
                                dec.exec_op    = alu_op(funct3, inst[30], 1'b0);
                                dec.rs1_source = RS_FROM_RF;
                                dec.rs1_idx    = inst[19:15];
                                dec.rs2_source = RS_FROM_IMM;
                                dec.rd_idx     = inst[11:7];
                                dec.rd_valid   = 1'b1;
                                // slli, srli and srai carry a shift amount
                                fmt            = (funct3[1:0] == 2'b01) ? IMM_SHAMT : IMM_I;
                        end
                        OP_REG: begin
                                dec.iq_code    = IQ_INT;
                                dec.fu_code    = FU_ALU;
                                dec.exec_op    = alu_op(funct3, inst[30], 1'b1);
                                dec.rs1_source = RS_FROM_RF;
                                dec.rs1_idx    = inst[19:15];
                                dec.rs2_source = RS_FROM_RF;
                                dec.rs2_idx    = inst[24:20];
                                dec.rd_idx     = inst[11:7];
                                dec.rd_valid   = 1'b1;
                        end
                        default: begin
                                hit = 1'b0;
                        end
                endcase
        end

        // empty slot or unknown encoding leaves the whole lane at zero
        always_comb begin
                uop = '0;
                if (valid && hit) begin
                        uop       = dec;
                        uop.valid = 1'b1;
                        uop.pc    = pc;
                        uop.imm   = imm;
                end
        end

endmodule

/* rtl/inst_decode.sv */
// ----------------------------------------------------------------------
// inst_decode
// Decode stage with one slot decoder per lane, registering the
// micro-ops and driving them out on flat per-lane vectors
// ----------------------------------------------------------------------
module inst_decode #(
        parameter int DECODE_WIDTH = 2
) (
        input  logic                                                 clock,
        input  logic                                                 rst_n,

        input  logic [DECODE_WIDTH*decode_pkg::XLEN-1:0]             fetch_pc,
        input  logic [DECODE_WIDTH*decode_pkg::XLEN-1:0]             fetch_inst,
        input  logic [DECODE_WIDTH-1:0]                              fetch_valid,

        output logic [DECODE_WIDTH-1:0]                              uop_valid,
        output logic [DECODE_WIDTH*decode_pkg::XLEN-1:0]             uop_pc,
        output logic [DECODE_WIDTH*$bits(decode_pkg::iq_code_e)-1:0] uop_iq_code,
        output logic [DECODE_WIDTH*$bits(decode_pkg::fu_code_e)-1:0] uop_fu_code,
        output logic [DECODE_WIDTH*$bits(decode_pkg::exec_op_e)-1:0] uop_exec_op,
        output logic [DECODE_WIDTH*decode_pkg::XLEN-1:0]             uop_imm,
        output logic [DECODE_WIDTH*$bits(decode_pkg::rs_source_e)-1:0] uop_rs1_source,
        output logic [DECODE_WIDTH*decode_pkg::ARF_IDX_W-1:0]        uop_rs1_idx,
        output logic [DECODE_WIDTH*$bits(decode_pkg::rs_source_e)-1:0] uop_rs2_source,
        output logic [DECODE_WIDTH*decode_pkg::ARF_IDX_W-1:0]        uop_rs2_idx,
        output logic [DECODE_WIDTH*decode_pkg::ARF_IDX_W-1:0]        uop_rd_idx,
        output logic [DECODE_WIDTH-1:0]                              uop_rd_valid,
        output logic [DECODE_WIDTH*$bits(decode_pkg::mem_size_e)-1:0] uop_mem_size
);

        import decode_pkg::*;

        localparam int IQ_W   = $bits(iq_code_e);
        localparam int FU_W   = $bits(fu_code_e);
        localparam int EXEC_W = $bits(exec_op_e);
        localparam int SRC_W  = $bits(rs_source_e);
        localparam int SIZE_W = $bits(mem_size_e);

        micro_op_t [DECODE_WIDTH-1:0] uop_d;
        micro_op_t [DECODE_WIDTH-1:0] uop_q;

        genvar i;
        generate
                for (i = 0; i < DECODE_WIDTH; i++) begin : g_lane
                        uop_decode u_uop_decode (
                                .pc    (fetch_pc[i*XLEN +: XLEN]),
                                .inst  (fetch_inst[i*XLEN +: XLEN]),
                                .valid (fetch_valid[i]),
                                .uop   (uop_d[i])
                        );

                        // unpack the registered record onto the lane slices
                        assign uop_valid[i]                       = uop_q[i].valid;
                        assign uop_pc[i*XLEN +: XLEN]             = uop_q[i].pc;
                        assign uop_iq_code[i*IQ_W +: IQ_W]        = uop_q[i].iq_code;
                        assign uop_fu_code[i*FU_W +: FU_W]        = uop_q[i].fu_code;
                        assign uop_exec_op[i*EXEC_W +: EXEC_W]    = uop_q[i].exec_op;
                        assign uop_imm[i*XLEN +: XLEN]            = uop_q[i].imm;
                        assign uop_rs1_source[i*SRC_W +: SRC_W]   = uop_q[i].rs1_source;
                        assign uop_rs1_idx[i*ARF_IDX_W +: ARF_IDX_W] = uop_q[i].rs1_idx;
                        assign uop_rs2_source[i*SRC_W +: SRC_W]   = uop_q[i].rs2_source;
                        assign uop_rs2_idx[i*ARF_IDX_W +: ARF_IDX_W] = uop_q[i].rs2_idx;
                        assign uop_rd_idx[i*ARF_IDX_W +: ARF_IDX_W]  = uop_q[i].rd_idx;
                        assign uop_rd_valid[i]                    = uop_q[i].rd_valid;
                        assign uop_mem_size[i*SIZE_W +: SIZE_W]   = uop_q[i].mem_size;
                end
        endgenerate

        // decode pipeline register takes a new bundle every cycle
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        uop_q <= '0;
                end else begin
                        uop_q <= uop_d;
                end
        end

endmodule

/* testbench/tb_inst_decode.sv */
// ----------------------------------------------------------------------
// tb_inst_decode
// Drives fetch bundles from the test data file through the decode
// stage and checks every registered micro-op lane
// ----------------------------------------------------------------------
module tb_inst_decode;

        timeunit 1ns;
        timeprecision 1ps;

        import decode_pkg::*;

        localparam int W             = 2;
        localparam int MAX_SLOTS     = 64;
        localparam int RESET_TIMEOUT = 20;
        localparam int IQ_W          = $bits(iq_code_e);
        localparam int FU_W          = $bits(fu_code_e);
        localparam int EXEC_W        = $bits(exec_op_e);
        localparam int SRC_W         = $bits(rs_source_e);
        localparam int SIZE_W        = $bits(mem_size_e);

        logic                   clock;
        logic                   rst_n;
        logic [W*XLEN-1:0]      fetch_pc;
        logic [W*XLEN-1:0]      fetch_inst;
        logic [W-1:0]           fetch_valid;
        logic [W-1:0]           uop_valid;
        logic [W*XLEN-1:0]      uop_pc;
        logic [W*IQ_W-1:0]      uop_iq_code;
        logic [W*FU_W-1:0]      uop_fu_code;
        logic [W*EXEC_W-1:0]    uop_exec_op;
        logic [W*XLEN-1:0]      uop_imm;
        logic [W*SRC_W-1:0]     uop_rs1_source;
        logic [W*ARF_IDX_W-1:0] uop_rs1_idx;
        logic [W*SRC_W-1:0]     uop_rs2_source;
        logic [W*ARF_IDX_W-1:0] uop_rs2_idx;
        logic [W*ARF_IDX_W-1:0] uop_rd_idx;
        logic [W-1:0]           uop_rd_valid;
        logic [W*SIZE_W-1:0]    uop_mem_size;

        logic [XLEN-1:0] d_pc [MAX_SLOTS];
        logic [XLEN-1:0] d_inst [MAX_SLOTS];
        logic            d_fv [MAX_SLOTS];
        micro_op_t       d_exp [MAX_SLOTS];
        int              n_slots;
        // lanes expected from the bundle driven one edge earlier
        micro_op_t       pend [W];
        logic [15:0]     lfsr;

        inst_decode #(
                .DECODE_WIDTH (W)
        ) UUT (
                .clock          (clock),
                .rst_n          (rst_n),
                .fetch_pc       (fetch_pc),
                .fetch_inst     (fetch_inst),
                .fetch_valid    (fetch_valid),
                .uop_valid      (uop_valid),
                .uop_pc         (uop_pc),
                .uop_iq_code    (uop_iq_code),
                .uop_fu_code    (uop_fu_code),
                .uop_exec_op    (uop_exec_op),
                .uop_imm        (uop_imm),
                .uop_rs1_source (uop_rs1_source),
                .uop_rs1_idx    (uop_rs1_idx),
                .uop_rs2_source (uop_rs2_source),
                .uop_rs2_idx    (uop_rs2_idx),
                .uop_rd_idx     (uop_rd_idx),
                .uop_rd_valid   (uop_rd_valid),
                .uop_mem_size   (uop_mem_size)
        );

        initial begin
                clock = 1'b0;
                forever #20 clock = ~clock;
        end

        // low for eight rising edges
        initial begin
                rst_n = 1'b1;
                #1 rst_n = 1'b0;
                repeat (8) @(posedge clock);
                #2 rst_n = 1'b1;
        end

        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
        endfunction

        function automatic micro_op_t lane_uop(input int l);
                micro_op_t u;
                u.valid      = uop_valid[l];
                u.pc         = uop_pc[l*XLEN +: XLEN];
                u.iq_code    = iq_code_e'(uop_iq_code[l*IQ_W +: IQ_W]);
                u.fu_code    = fu_code_e'(uop_fu_code[l*FU_W +: FU_W]);
                u.exec_op    = exec_op_e'(uop_exec_op[l*EXEC_W +: EXEC_W]);
                u.imm        = uop_imm[l*XLEN +: XLEN];
                u.rs1_source = rs_source_e'(uop_rs1_source[l*SRC_W +: SRC_W]);
                u.rs1_idx    = uop_rs1_idx[l*ARF_IDX_W +: ARF_IDX_W];
                u.rs2_source = rs_source_e'(uop_rs2_source[l*SRC_W +: SRC_W]);
                u.rs2_idx    = uop_rs2_idx[l*ARF_IDX_W +: ARF_IDX_W];
                u.rd_idx     = uop_rd_idx[l*ARF_IDX_W +: ARF_IDX_W];
                u.rd_valid   = uop_rd_valid[l];
                u.mem_size   = mem_size_e'(uop_mem_size[l*SIZE_W +: SIZE_W]);
                return u;
        endfunction

        task automatic check_valid(input logic [W-1:0] got, input logic [W-1:0] exp);
                if (got !== exp) begin
                        $display("ERR %0t uop_valid got %b expected %b", $time, got, exp);
                        $display("TEST FAIL");
                        $fatal(1);
                end
        endtask

        task automatic check_uop(input int l, input micro_op_t got, input micro_op_t exp);
                if (got !== exp) begin
                        $display("ERR %0t lane %0d micro-op got %h expected %h",
                                 $time, l, got, exp);
                        $display("TEST FAIL");
                        $fatal(1);
                end
        endtask

        task automatic check_outputs();
                logic [W-1:0] exp_v;
                for (int l = 0; l < W; l++) begin
                        exp_v[l] = pend[l].valid;
                end
                check_valid(uop_valid, exp_v);
                for (int l = 0; l < W; l++) begin
                        check_uop(l, lane_uop(l), pend[l]);
                end
        endtask

        // a negative slot gives an idle cycle with every fetch_valid low
        task automatic run_cycle(input int slot);
                micro_op_t nxt [W];
                @(posedge clock);
                #2;
                for (int l = 0; l < W; l++) begin
                        nxt[l]         = '0;
                        fetch_valid[l] = 1'b0;
                        if (slot >= 0) begin
                                fetch_pc[l*XLEN +: XLEN]   = d_pc[slot+l];
                                fetch_inst[l*XLEN +: XLEN] = d_inst[slot+l];
                                fetch_valid[l]             = d_fv[slot+l];
                                nxt[l]                     = d_exp[slot+l];
                        end
                end
                #36;
                check_outputs();
                pend = nxt;
        endtask

        task automatic load_testdata();
                int              fd;
                int              n;
                string           line;
                logic [XLEN-1:0] f [15];
                fd = $fopen("testbench/inst_decode_testdata.txt", "r");
                if (fd == 0) begin
                        $display("could not open testbench/inst_decode_testdata.txt");
                        $display("TEST FAIL");
                        $fatal(1);
                end
                n_slots = 0;
                while ($fgets(line, fd) != 0) begin
                        if (line.len() < 2 || line.getc(0) == "#") begin
                                continue;
                        end
                        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                    f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                        if (n != 15 || n_slots == MAX_SLOTS) begin
                                $display("unreadable or surplus test data line: %s", line);
                                $display("TEST FAIL");
                                $fatal(1);
                        end
                        d_pc[n_slots]                = f[0];
                        d_inst[n_slots]              = f[1];
                        d_fv[n_slots]                = f[2][0];
                        d_exp[n_slots]               = '0;
                        d_exp[n_slots].valid         = f[3][0];
                        // a dropped slot carries no pc
                        d_exp[n_slots].pc            = f[3][0] ? f[0] : '0;
                        d_exp[n_slots].iq_code       = iq_code_e'(f[4][IQ_W-1:0]);
                        d_exp[n_slots].fu_code       = fu_code_e'(f[5][FU_W-1:0]);
                        d_exp[n_slots].exec_op       = exec_op_e'(f[6][EXEC_W-1:0]);
                        d_exp[n_slots].imm           = f[7];
                        d_exp[n_slots].rs1_source    = rs_source_e'(f[8][SRC_W-1:0]);
                        d_exp[n_slots].rs1_idx       = f[9][ARF_IDX_W-1:0];
                        d_exp[n_slots].rs2_source    = rs_source_e'(f[10][SRC_W-1:0]);
                        d_exp[n_slots].rs2_idx       = f[11][ARF_IDX_W-1:0];
                        d_exp[n_slots].rd_idx        = f[12][ARF_IDX_W-1:0];
                        d_exp[n_slots].rd_valid      = f[13][0];
                        d_exp[n_slots].mem_size      = mem_size_e'(f[14][SIZE_W-1:0]);
                        n_slots++;
                end
                $fclose(fd);
        endtask

        initial begin
                int cycles;
                int idle;
                fetch_pc    = '0;
                fetch_inst  = '0;
                fetch_valid = '0;
                lfsr        = 16'd2;
                for (int l = 0; l < W; l++) begin
                        pend[l] = '0;
                end
                load_testdata();
                cycles = 0;
                // all lanes stay clear while reset is held
                do begin
                        if (cycles == RESET_TIMEOUT) begin
                                $display("reset still asserted after %0d cycles", cycles);
                                $display("TEST FAIL");
                                $fatal(1);
                        end
                        @(posedge clock);
                        #38;
                        check_outputs();
                        cycles++;
                end while (rst_n !== 1'b1);
                for (int b = 0; b + W <= n_slots; b += W) begin
                        idle = 0;
                        for (int k = 0; k < 2; k++) begin
                                lfsr = lfsr_next(lfsr);
                                idle = (idle << 1) | int'(lfsr[0]);
                        end
                        repeat (idle) run_cycle(-1);
                        run_cycle(b);
                end
                // one more edge to see the last bundle
                run_cycle(-1);
                $display("TEST PASS");
                $finish;
        end

endmodule

/* testbench/inst_decode_testdata.txt */
# pc inst fetch_valid | expected: valid iq fu exec_op imm rs1_src rs1_idx rs2_src rs2_idx rd rd_valid mem_size
# all fields hex; two lines form one bundle, lane 0 first
00001000 123452b7 1  1 1 1 01 12345000 1 00 3 00 05 1 0
00001004 fffff517 1  1 1 1 01 fffff000 2 00 3 00 0a 1 0
00001008 00208463 1  1 1 2 0b 00000000 0 01 0 02 00 0 0
0000100c 00419463 1  1 1 2 0c 00000000 0 03 0 04 00 0 0
00001010 0062c463 1  1 1 2 0d 00000000 0 05 0 06 00 0 0
00001014 0083d463 1  1 1 2 0e 00000000 0 07 0 08 00 0 0
00001018 00a4e463 1  1 1 2 0f 00000000 0 09 0 0a 00 0 0
0000101c 80c5f463 1  1 1 2 10 00000000 0 0b 0 0c 00 0 0
00001020 ffc10083 1  1 2 3 11 fffffffc 0 02 3 00 01 1 0
00001024 7fe21183 1  1 2 3 11 000007fe 0 04 3 00 03 1 1
00001028 01032283 1  1 2 3 11 00000010 0 06 3 00 05 1 2
0000102c 00144383 1  1 2 3 12 00000001 0 08 3 00 07 1 0
00001030 ffe55483 1  1 2 3 12 fffffffe 0 0a 3 00 09 1 1
00001034 00b602a3 1  1 2 3 13 00000005 0 0c 0 0b 00 0 0
00001038 fed71c23 1  1 2 3 13 fffffff8 0 0e 0 0d 00 0 1
0000103c 10f82023 1  1 2 3 13 00000100 0 10 0 0f 00 0 2
00001040 fff10093 1  1 1 1 01 ffffffff 0 02 3 00 01 1 0
00001044 06422193 1  1 1 1 04 00000064 0 04 3 00 03 1 0
00001048 80033293 1  1 1 1 05 fffff800 0 06 3 00 05 1 0
0000104c 0ff44393 1  1 1 1 06 000000ff 0 08 3 00 07 1 0
00001050 55556493 1  1 1 1 09 00000555 0 0a 3 00 09 1 0
00001054 ff067593 1  1 1 1 0a fffffff0 0 0c 3 00 0b 1 0
00001058 01f71693 1  1 1 1 03 0000001f 0 0e 3 00 0d 1 0
0000105c 00485793 1  1 1 1 07 00000004 0 10 3 00 0f 1 0
00001060 41495893 1  1 1 1 08 00000014 0 12 3 00 11 1 0
00001064 003100b3 1  1 1 1 01 00000000 0 02 0 03 01 1 0
00001068 40628233 1  1 1 1 02 00000000 0 05 0 06 04 1 0
0000106c 009413b3 1  1 1 1 03 00000000 0 08 0 09 07 1 0
00001070 00c5a533 1  1 1 1 04 00000000 0 0b 0 0c 0a 1 0
00001074 00f736b3 1  1 1 1 05 00000000 0 0e 0 0f 0d 1 0
00001078 0128c833 1  1 1 1 06 00000000 0 11 0 12 10 1 0
0000107c 008000ef 1  0 0 0 00 00000000 0 00 0 00 00 0 0
00001080 000280e7 1  0 0 0 00 00000000 0 00 0 00 00 0 0
00001084 015a59b3 1  1 1 1 07 00000000 0 14 0 15 13 1 0
00001088 418bdb33 1  1 1 1 08 00000000 0 17 0 18 16 1 0
0000108c 00000073 1  0 0 0 00 00000000 0 00 0 00 00 0 0
00001090 0ff0000f 1  0 0 0 00 00000000 0 00 0 00 00 0 0
00001094 01bd6cb3 1  1 1 1 09 00000000 0 1a 0 1b 19 1 0
00001098 01eefe33 1  1 1 1 0a 00000000 0 1d 0 1e 1c 1 0
0000109c 003100b3 0  0 0 0 00 00000000 0 00 0 00 00 0 0
000010a0 0000007f 1  0 0 0 00 00000000 0 00 0 00 00 0 0
000010a4 80000fb7 1  1 1 1 01 80000000 1 00 3 00 1f 1 0

/* inst_decode.f */
rtl/decode_pkg.sv
rtl/imm_gen.sv
rtl/uop_decode.sv
rtl/inst_decode.sv
testbench/tb_inst_decode.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_inst_decode \
        -f inst_decode.f -Mdir obj_dir -o sim_inst_decode

./obj_dir/sim_inst_decode | tee sim.log

if grep -q "TEST FAIL" sim.log; then
        echo "simulation failed"
        exit 1
fi
echo "simulation passed"
